/* common/id_pkg.sv */
`default_nettype none

package id_pkg;

  // ==========================================================================
  // Widths
  // ==========================================================================
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;

  // RV32I major opcodes
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;

  // ALU operand A source
  localparam logic [1:0] ALU_A_RS1  = 2'd0;
  localparam logic [1:0] ALU_A_PC   = 2'd1;
  localparam logic [1:0] ALU_A_ZERO = 2'd2;

  // ALU operation class, refined in EX from funct3/funct7
  localparam logic [1:0] ALU_OP_ADD    = 2'd0;
  localparam logic [1:0] ALU_OP_BRANCH = 2'd1;
  localparam logic [1:0] ALU_OP_REG    = 2'd2;
  localparam logic [1:0] ALU_OP_IMM    = 2'd3;

  typedef enum logic [2:0] {
    IMM_I,
    IMM_S,
    IMM_B,
    IMM_U,
    IMM_J
  } imm_type_e;

  typedef enum logic [1:0] {
    TRAP_NONE,
    TRAP_INSTR_INVALID
  } trap_code_e;

  typedef enum logic [1:0] {
    RES_ALU,
    RES_MEM,
    RES_PC4
  } res_src_e;

  // ==========================================================================
  // Stage payloads
  // ==========================================================================

  // Control payload, cleared when the stage is flushed
  typedef struct packed {
    logic reg_write;
    logic mem_read;
    logic mem_write;
    logic is_branch;
    logic is_jal;
    logic is_jalr;
    logic trap;
    logic bpred_taken;
  } id_ctrl_t;

  // Datapath payload, held across a flush
  typedef struct packed {
    logic [1:0]            alu_a_src;
    logic                  alu_b_src;
    logic [1:0]            alu_op;
    res_src_e              res_src;
    trap_code_e            trap_code;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       pc_plus4;
    logic [XLEN-1:0]       pred_tgt;
  } id_data_t;

  typedef struct packed {
    logic                  reg_write;
    logic                  mem_read;
    logic                  mem_write;
    logic                  is_branch;
    logic                  is_jal;
    logic                  is_jalr;
    logic                  trap;
    logic [1:0]            alu_a_src;
    logic                  alu_b_src;
    logic [1:0]            alu_op;
    res_src_e              res_src;
    trap_code_e            trap_code;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [XLEN-1:0]       imm;
    logic                  rs1_used;
    logic                  rs2_used;
  } dec_out_t;

  // Write-back port into the register file
  typedef struct packed {
    logic                  wen;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       data;
  } wb_t;

endpackage

`default_nettype wire

/* decode/instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
  input  wire logic [31:0]     instr_i,
  output id_pkg::dec_out_t     dec_o
);

  logic [6:0]                 opcode;
  id_pkg::imm_type_e          imm_type;
  logic [id_pkg::XLEN-1:0]    imm_i;
  logic [id_pkg::XLEN-1:0]    imm_s;
  logic [id_pkg::XLEN-1:0]    imm_b;
  logic [id_pkg::XLEN-1:0]    imm_u;
  logic [id_pkg::XLEN-1:0]    imm_j;

  assign opcode = instr_i[6:0];

  // ==========================================================================
  // Immediate formats, all sign-extended from bit 31
  // ==========================================================================
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  // ==========================================================================
  // Control decode
  // ==========================================================================
  always_comb begin
    dec_o           = '0;
    imm_type        = id_pkg::IMM_I;

    // Raw fields pass through whatever the format
    dec_o.rd        = instr_i[11:7];
    dec_o.rs1       = instr_i[19:15];
    dec_o.rs2       = instr_i[24:20];
    dec_o.funct3    = instr_i[14:12];
    dec_o.funct7    = instr_i[31:25];
    dec_o.alu_a_src = id_pkg::ALU_A_RS1;
    dec_o.alu_op    = id_pkg::ALU_OP_ADD;
    dec_o.res_src   = id_pkg::RES_ALU;
    dec_o.trap_code = id_pkg::TRAP_NONE;

    case (opcode)
      id_pkg::OP_LUI: begin
        dec_o.reg_write = 1'b1;
        dec_o.alu_a_src = id_pkg::ALU_A_ZERO;
        dec_o.alu_b_src = 1'b1;
        imm_type        = id_pkg::IMM_U;
      end
      id_pkg::OP_AUIPC: begin
        dec_o.reg_write = 1'b1;
        dec_o.alu_a_src = id_pkg::ALU_A_PC;
        dec_o.alu_b_src = 1'b1;
        imm_type        = id_pkg::IMM_U;
      end
      id_pkg::OP_JAL: begin
        dec_o.reg_write = 1'b1;
        dec_o.is_jal    = 1'b1;
        dec_o.alu_a_src = id_pkg::ALU_A_PC;
        dec_o.alu_b_src = 1'b1;
        dec_o.res_src   = id_pkg::RES_PC4;
        imm_type        = id_pkg::IMM_J;
      end
      id_pkg::OP_JALR: begin
        dec_o.reg_write = 1'b1;
        dec_o.is_jalr   = 1'b1;
        dec_o.alu_b_src = 1'b1;
        dec_o.res_src   = id_pkg::RES_PC4;
        dec_o.rs1_used  = 1'b1;
      end
      id_pkg::OP_BRANCH: begin
        dec_o.is_branch = 1'b1;
        dec_o.alu_op    = id_pkg::ALU_OP_BRANCH;
        dec_o.rs1_used  = 1'b1;
        dec_o.rs2_used  = 1'b1;
        imm_type        = id_pkg::IMM_B;
      end
      id_pkg::OP_LOAD: begin
        dec_o.reg_write = 1'b1;
        dec_o.mem_read  = 1'b1;
        dec_o.alu_b_src = 1'b1;
        dec_o.res_src   = id_pkg::RES_MEM;
        dec_o.rs1_used  = 1'b1;
      end
      id_pkg::OP_STORE: begin
        dec_o.mem_write = 1'b1;
        dec_o.alu_b_src = 1'b1;
        dec_o.rs1_used  = 1'b1;
        dec_o.rs2_used  = 1'b1;
        imm_type        = id_pkg::IMM_S;
      end
      id_pkg::OP_IMM: begin
        dec_o.reg_write = 1'b1;
        dec_o.alu_b_src = 1'b1;
        dec_o.alu_op    = id_pkg::ALU_OP_IMM;
        dec_o.rs1_used  = 1'b1;
      end
      id_pkg::OP_REG: begin
        dec_o.reg_write = 1'b1;
        dec_o.alu_op    = id_pkg::ALU_OP_REG;
        dec_o.rs1_used  = 1'b1;
        dec_o.rs2_used  = 1'b1;
      end
      default: begin
        // Unknown opcode raises a trap with no side effects
        dec_o.trap      = 1'b1;
        dec_o.trap_code = id_pkg::TRAP_INSTR_INVALID;
      end
    endcase

    case (imm_type)
      id_pkg::IMM_S: dec_o.imm = imm_s;
      id_pkg::IMM_B: dec_o.imm = imm_b;
      id_pkg::IMM_U: dec_o.imm = imm_u;
      id_pkg::IMM_J: dec_o.imm = imm_j;
      default:       dec_o.imm = imm_i;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  wire logic                          clk,
  input  wire logic                          arst_n_i,
  input  wire logic [id_pkg::REG_ADDR_W-1:0] rs1_addr_i,
  input  wire logic [id_pkg::REG_ADDR_W-1:0] rs2_addr_i,
  input  id_pkg::wb_t                        wb_i,
  output logic      [id_pkg::XLEN-1:0]       rs1_data_o,
  output logic      [id_pkg::XLEN-1:0]       rs2_data_o
);

  // x0 has no storage
  logic [id_pkg::XLEN-1:0] regs [id_pkg::NUM_REGS-1:1];
  logic                    wr_en;
  logic                    byp_rs1;
  logic                    byp_rs2;

  assign wr_en = wb_i.wen && (wb_i.rd != '0);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 1; i < id_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wb_i.rd] <= wb_i.data;
    end
  end

  // Same-cycle write-back bypass
  assign byp_rs1 = wr_en && (wb_i.rd == rs1_addr_i);
  assign byp_rs2 = wr_en && (wb_i.rd == rs2_addr_i);

  always_comb begin
    if (rs1_addr_i == '0) begin
      rs1_data_o = '0;
    end else if (byp_rs1) begin
      rs1_data_o = wb_i.data;
    end else begin
      rs1_data_o = regs[rs1_addr_i];
    end

    if (rs2_addr_i == '0) begin
      rs2_data_o = '0;
    end else if (byp_rs2) begin
      rs2_data_o = wb_i.data;
    end else begin
      rs2_data_o = regs[rs2_addr_i];
    end
  end

endmodule

`default_nettype wire

/* verilog/static_bpred.sv */
`timescale 1ns/1ps
`default_nettype none

module static_bpred (
  input  wire logic [id_pkg::XLEN-1:0] pc_i,
  input  wire logic [id_pkg::XLEN-1:0] imm_i,
  input  wire logic                    is_branch_i,
  input  wire logic                    is_jal_i,
  input  wire logic                    is_jalr_i,
  output logic                         pred_taken_o,
  output logic      [id_pkg::XLEN-1:0] pred_tgt_o
);

  logic [id_pkg::XLEN-1:0] pc_rel_tgt;
  logic                    backward;

  // PC-relative target shared by branches and JAL
  assign pc_rel_tgt = pc_i + imm_i;

  // Negative offset means a loop edge
  assign backward = imm_i[id_pkg::XLEN-1];

  // Backward taken, forward not taken, JAL always taken
  assign pred_taken_o = is_jal_i || (is_branch_i && backward);

  // JALR target depends on rs1 and is left to EX
  assign pred_tgt_o = is_jalr_i ? '0 : pc_rel_tgt;

endmodule

`default_nettype wire

/* verilog/id_ex_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg #(
  parameter type payload_t      = logic,
  parameter bit  CLEAR_ON_FLUSH = 1'b0
) (
  input  wire logic clk,
  input  wire logic arst_n_i,
  input  wire logic flush_i,
  input  wire logic s_valid_i,
  output logic      s_ready_o,
  input  payload_t  s_data_i,
  output logic      m_valid_o,
  input  wire logic m_ready_i,
  output payload_t  m_data_o
);

  logic accept;

  // Empty or draining this cycle
  assign s_ready_o = !m_valid_o || m_ready_i;
  assign accept    = s_valid_i && s_ready_o;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      m_valid_o <= 1'b0;
    end else if (flush_i) begin
      m_valid_o <= 1'b0;
    end else if (s_ready_o) begin
      m_valid_o <= s_valid_i;
    end
  end

  // ==========================================================================
  // Payload storage
  // ==========================================================================
  if (CLEAR_ON_FLUSH) begin : g_clear
    // Control bits must read as a bubble after reset or flush
    always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
        m_data_o <= '0;
      end else if (flush_i) begin
        m_data_o <= '0;
      end else if (accept) begin
        m_data_o <= s_data_i;
      end
    end
  end else begin : g_hold
    always_ff @(posedge clk) begin
      if (accept && !flush_i) begin
        m_data_o <= s_data_i;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  wire logic                    clk,
  input  wire logic                    arst_n_i,
  input  wire logic                    flush_i,
  input  wire logic                    s_valid_i,
  output logic                         s_ready_o,
  input  wire logic [31:0]             instr_i,
  input  wire logic [id_pkg::XLEN-1:0] pc_i,
  input  id_pkg::wb_t                  wb_i,
  output logic                         m_valid_o,
  input  wire logic                    m_ready_i,
  output id_pkg::id_ctrl_t             ctrl_o,
  output id_pkg::id_data_t             data_o,
  output logic                         pred_taken_o,
  output logic      [id_pkg::XLEN-1:0] pred_tgt_o
);

  id_pkg::dec_out_t                dec;
  logic [id_pkg::REG_ADDR_W-1:0]   rf_rs1_addr;
  logic [id_pkg::REG_ADDR_W-1:0]   rf_rs2_addr;
  logic [id_pkg::XLEN-1:0]         rs1_data;
  logic [id_pkg::XLEN-1:0]         rs2_data;
  logic [id_pkg::XLEN-1:0]         pc_plus4;
  id_pkg::id_ctrl_t                ctrl_d;
  id_pkg::id_data_t                data_d;

  instr_decoder u_decoder (
    .instr_i (instr_i),
    .dec_o   (dec)
  );

  // Operands the instruction does not use read as x0
  assign rf_rs1_addr = dec.rs1_used ? dec.rs1 : '0;
  assign rf_rs2_addr = dec.rs2_used ? dec.rs2 : '0;

  reg_file u_reg_file (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .rs1_addr_i (rf_rs1_addr),
    .rs2_addr_i (rf_rs2_addr),
    .wb_i       (wb_i),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  static_bpred u_bpred (
    .pc_i         (pc_i),
    .imm_i        (dec.imm),
    .is_branch_i  (dec.is_branch),
    .is_jal_i     (dec.is_jal),
    .is_jalr_i    (dec.is_jalr),
    .pred_taken_o (pred_taken_o),
    .pred_tgt_o   (pred_tgt_o)
  );

  assign pc_plus4 = pc_i + 32'd4;

  // ==========================================================================
  // Payload packing
  // ==========================================================================
  always_comb begin
    ctrl_d.reg_write   = dec.reg_write;
    ctrl_d.mem_read    = dec.mem_read;
    ctrl_d.mem_write   = dec.mem_write;
    ctrl_d.is_branch   = dec.is_branch;
    ctrl_d.is_jal      = dec.is_jal;
    ctrl_d.is_jalr     = dec.is_jalr;
    ctrl_d.trap        = dec.trap;
    ctrl_d.bpred_taken = pred_taken_o;

    data_d.alu_a_src   = dec.alu_a_src;
    data_d.alu_b_src   = dec.alu_b_src;
    data_d.alu_op      = dec.alu_op;
    data_d.res_src     = dec.res_src;
    data_d.trap_code   = dec.trap_code;
    data_d.rd          = dec.rd;
    data_d.rs1         = dec.rs1;
    data_d.rs2         = dec.rs2;
    data_d.funct3      = dec.funct3;
    data_d.funct7      = dec.funct7;
    data_d.rs1_data    = rs1_data;
    data_d.rs2_data    = rs2_data;
    data_d.imm         = dec.imm;
    data_d.pc          = pc_i;
    data_d.pc_plus4    = pc_plus4;
    data_d.pred_tgt    = pred_tgt_o;
  end

  // Control register owns the handshake for both halves
  id_ex_reg #(
    .payload_t      (id_pkg::id_ctrl_t),
    .CLEAR_ON_FLUSH (1'b1)
  ) u_ctrl_reg (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .flush_i   (flush_i),
    .s_valid_i (s_valid_i),
    .s_ready_o (s_ready_o),
    .s_data_i  (ctrl_d),
    .m_valid_o (m_valid_o),
    .m_ready_i (m_ready_i),
    .m_data_o  (ctrl_o)
  );

  id_ex_reg #(
    .payload_t      (id_pkg::id_data_t),
    .CLEAR_ON_FLUSH (1'b0)
  ) u_data_reg (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .flush_i   (flush_i),
    .s_valid_i (s_valid_i),
    .s_ready_o (),
    .s_data_i  (data_d),
    .m_valid_o (),
    .m_ready_i (m_ready_i),
    .m_data_o  (data_o)
  );

endmodule

`default_nettype wire

/* testbench/decode_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage_tb;

  localparam int CLK_PERIOD  = 4;
  localparam int HS_LIMIT    = 100;
  // Rough cycle budget of all tests, plus a margin
  localparam int TEST_CYCLES = 400;
  localparam int WATCHDOG_NS = (TEST_CYCLES + 100) * CLK_PERIOD;

  logic                    clk;
  logic                    arst_n_i;
  logic                    flush_i;
  logic                    s_valid_i;
  logic                    s_ready_o;
  logic [31:0]             instr_i;
  logic [31:0]             pc_i;
  id_pkg::wb_t             wb_i;
  logic                    m_valid_o;
  logic                    m_ready_i = 1'b1;
  id_pkg::id_ctrl_t        ctrl_o;
  id_pkg::id_data_t        data_o;
  logic                    pred_taken_o;
  logic [31:0]             pred_tgt_o;

  integer                  seed = 32;
  int                      err_cnt = 0;
  int                      err_mark = 0;
  int                      n_tests = 0;
  int                      n_out = 0;
  int                      n_out_dut = 0;
  logic [31:0]             pc_next = 32'h0000_1000;
  logic                    bp_en = 1'b0;
  logic [31:0]             bp_pattern = '0;
  logic [4:0]              bp_idx = '0;
  logic [6:0]              opcodes [0:9];

  // Reference model state
  logic [31:0]             ref_regs [0:31];
  id_pkg::id_ctrl_t        ctrl_q [$];
  id_pkg::id_data_t        data_q [$];
  logic                    exp_valid = 1'b0;
  logic                    ctrl_cleared = 1'b1;
  id_pkg::id_ctrl_t        exp_ctrl = '0;
  id_pkg::id_data_t        exp_data = '0;
  logic                    exp_pred_taken;
  logic [31:0]             exp_pred_tgt;

  decode_stage u_decode_stage (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .flush_i      (flush_i),
    .s_valid_i    (s_valid_i),
    .s_ready_o    (s_ready_o),
    .instr_i      (instr_i),
    .pc_i         (pc_i),
    .wb_i         (wb_i),
    .m_valid_o    (m_valid_o),
    .m_ready_i    (m_ready_i),
    .ctrl_o       (ctrl_o),
    .data_o       (data_o),
    .pred_taken_o (pred_taken_o),
    .pred_tgt_o   (pred_tgt_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ==========================================================================
  // Reference rules
  // ==========================================================================
  function automatic logic [31:0] ref_imm(input logic [31:0] ins);
    logic signed [31:0] t;
    int                 sh;
    t  = {ins[31:20], 20'b0};
    sh = 20;
    case (ins[6:0])
      id_pkg::OP_STORE: t = {ins[31:25], ins[11:7], 20'b0};
      id_pkg::OP_BRANCH: begin
        t  = {ins[31], ins[7], ins[30:25], ins[11:8], 1'b0, 19'b0};
        sh = 19;
      end
      id_pkg::OP_LUI, id_pkg::OP_AUIPC: begin
        t  = {ins[31:12], 12'b0};
        sh = 0;
      end
      id_pkg::OP_JAL: begin
        t  = {ins[31], ins[19:12], ins[20], ins[30:21], 1'b0, 11'b0};
        sh = 11;
      end
      default: ;
    endcase
    return t >>> sh;
  endfunction

  function automatic logic ref_pred_taken(input logic [31:0] ins);
    logic [31:0] imm;
    imm = ref_imm(ins);
    return (ins[6:0] == id_pkg::OP_JAL) || (ins[6:0] == id_pkg::OP_BRANCH && imm[31]);
  endfunction

  function automatic logic [31:0] ref_pred_tgt(input logic [31:0] ins, input logic [31:0] pc);
    return (ins[6:0] == id_pkg::OP_JALR) ? 32'h0 : pc + ref_imm(ins);
  endfunction

  function automatic void ref_decode(input logic [31:0] ins, input logic [31:0] pc,
                                     output id_pkg::id_ctrl_t c, output id_pkg::id_data_t d);
    logic [6:0] op;
    logic       use_rs1;
    logic       use_rs2;
    op = ins[6:0];
    c  = '0;
    d  = '0;
    // Operand use follows the RV32I instruction formats
    use_rs1 = op inside {id_pkg::OP_JALR, id_pkg::OP_BRANCH, id_pkg::OP_LOAD,
                         id_pkg::OP_STORE, id_pkg::OP_IMM, id_pkg::OP_REG};
    use_rs2 = op inside {id_pkg::OP_BRANCH, id_pkg::OP_STORE, id_pkg::OP_REG};
    c.reg_write = op inside {id_pkg::OP_LUI, id_pkg::OP_AUIPC, id_pkg::OP_JAL,
                             id_pkg::OP_JALR, id_pkg::OP_LOAD, id_pkg::OP_IMM, id_pkg::OP_REG};
    c.mem_read  = (op == id_pkg::OP_LOAD);
    c.mem_write = (op == id_pkg::OP_STORE);
    c.is_branch = (op == id_pkg::OP_BRANCH);
    c.is_jal    = (op == id_pkg::OP_JAL);
    c.is_jalr   = (op == id_pkg::OP_JALR);
    c.trap      = !(use_rs1 || c.reg_write || op == id_pkg::OP_STORE);
    c.bpred_taken = ref_pred_taken(ins);
    if (c.trap) begin
      d.trap_code = id_pkg::TRAP_INSTR_INVALID;
    end else begin
      d.trap_code = id_pkg::TRAP_NONE;
    end
    // LUI adds to zero, AUIPC and JAL add to the pc
    if (op == id_pkg::OP_LUI) begin
      d.alu_a_src = id_pkg::ALU_A_ZERO;
    end else if (op == id_pkg::OP_AUIPC || op == id_pkg::OP_JAL) begin
      d.alu_a_src = id_pkg::ALU_A_PC;
    end else begin
      d.alu_a_src = id_pkg::ALU_A_RS1;
    end
    // Every format with an immediate operand feeds it to ALU input B
    d.alu_b_src = op inside {id_pkg::OP_LUI, id_pkg::OP_AUIPC, id_pkg::OP_JAL,
                             id_pkg::OP_JALR, id_pkg::OP_LOAD, id_pkg::OP_STORE,
                             id_pkg::OP_IMM};
    case (op)
      id_pkg::OP_BRANCH: d.alu_op = id_pkg::ALU_OP_BRANCH;
      id_pkg::OP_REG:    d.alu_op = id_pkg::ALU_OP_REG;
      id_pkg::OP_IMM:    d.alu_op = id_pkg::ALU_OP_IMM;
      default:           d.alu_op = id_pkg::ALU_OP_ADD;
    endcase
    if (c.mem_read) begin
      d.res_src = id_pkg::RES_MEM;
    end else if (c.is_jal || c.is_jalr) begin
      d.res_src = id_pkg::RES_PC4;
    end else begin
      d.res_src = id_pkg::RES_ALU;
    end
    d.rd       = ins[11:7];
    d.rs1      = ins[19:15];
    d.rs2      = ins[24:20];
    d.funct3   = ins[14:12];
    d.funct7   = ins[31:25];
    d.rs1_data = use_rs1 ? ref_regs[ins[19:15]] : 32'h0;
    d.rs2_data = use_rs2 ? ref_regs[ins[24:20]] : 32'h0;
    d.imm      = ref_imm(ins);
    d.pc       = pc;
    d.pc_plus4 = pc + 32'd4;
    d.pred_tgt = ref_pred_tgt(ins, pc);
  endfunction

  // Stage model, one item deep
  always @(posedge clk or negedge arst_n_i) begin
    id_pkg::id_ctrl_t c;
    id_pkg::id_data_t d;
    logic             ready;
    if (!arst_n_i) begin
      for (int i = 0; i < 32; i++) begin
        ref_regs[i] = '0;
      end
      ctrl_q.delete();
      data_q.delete();
      exp_valid    = 1'b0;
      ctrl_cleared = 1'b1;
    end else begin
      ready = !exp_valid || m_ready_i;
      // Write-back lands before the read so a same-cycle write is seen
      if (wb_i.wen && wb_i.rd != 5'd0) begin
        ref_regs[wb_i.rd] = wb_i.data;
      end
      if (exp_valid && m_ready_i) begin
        void'(ctrl_q.pop_front());
        void'(data_q.pop_front());
        n_out++;
      end
      if (flush_i) begin
        ctrl_q.delete();
        data_q.delete();
        ctrl_cleared = 1'b1;
      end else if (s_valid_i && ready) begin
        ref_decode(instr_i, pc_i, c, d);
        ctrl_q.push_back(c);
        data_q.push_back(d);
        ctrl_cleared = 1'b0;
      end
      exp_valid = (ctrl_q.size() != 0);
      if (exp_valid) begin
        exp_ctrl = ctrl_q[0];
        exp_data = data_q[0];
      end
    end
  end

  always @(posedge clk) begin
    if (arst_n_i && m_valid_o && m_ready_i) begin
      n_out_dut++;
    end
  end

  always_comb begin
    exp_pred_taken = ref_pred_taken(instr_i);
    exp_pred_tgt   = ref_pred_tgt(instr_i, pc_i);
  end

  always @(posedge clk) begin
    m_ready_i <= bp_en ? bp_pattern[bp_idx] : 1'b1;
    bp_idx    <= bp_idx + 5'd1;
  end

  // ==========================================================================
  // Checks
  // ==========================================================================
  function automatic void log_mismatch(input string name, input logic [255:0] exp_v,
                                       input logic [255:0] act_v);
    $display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, exp_v, act_v);
    err_cnt++;
  endfunction

  function automatic void log_problem(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    err_cnt++;
  endfunction

  a_valid: assert property (@(negedge clk) disable iff (!arst_n_i) m_valid_o == exp_valid)
    else log_mismatch("m_valid_o", 256'(exp_valid), 256'(m_valid_o));
  a_ready: assert property (@(negedge clk) disable iff (!arst_n_i)
                            s_ready_o == (!exp_valid || m_ready_i))
    else log_mismatch("s_ready_o", 256'(!exp_valid || m_ready_i), 256'(s_ready_o));
  a_ctrl: assert property (@(negedge clk) disable iff (!arst_n_i)
                           exp_valid |-> ctrl_o == exp_ctrl)
    else log_mismatch("ctrl_o", 256'(exp_ctrl), 256'(ctrl_o));
  a_data: assert property (@(negedge clk) disable iff (!arst_n_i)
                           exp_valid |-> data_o == exp_data)
    else log_mismatch("data_o", 256'(exp_data), 256'(data_o));
  a_ctrl_clear: assert property (@(negedge clk) disable iff (!arst_n_i)
                                 ctrl_cleared |-> ctrl_o == '0)
    else log_mismatch("ctrl_o", 256'(0), 256'(ctrl_o));
  a_pred_taken: assert property (@(negedge clk) disable iff (!arst_n_i)
                                 s_valid_i |-> pred_taken_o == exp_pred_taken)
    else log_mismatch("pred_taken_o", 256'(exp_pred_taken), 256'(pred_taken_o));
  a_pred_tgt: assert property (@(negedge clk) disable iff (!arst_n_i)
                               s_valid_i |-> pred_tgt_o == exp_pred_tgt)
    else log_mismatch("pred_tgt_o", 256'(exp_pred_tgt), 256'(pred_tgt_o));
  a_hold: assert property (@(negedge clk) disable iff (!arst_n_i)
                           (m_valid_o && !m_ready_i) |=> $stable(data_o))
    else log_problem("data_o changed while held under back-pressure");

  // ==========================================================================
  // Stimulus
  // ==========================================================================
  function automatic logic [31:0] make_instr(input logic [6:0] op);
    logic [31:0] ins;
    ins      = $random(seed);
    ins[6:0] = op;
    return ins;
  endfunction

  task automatic send(input logic [31:0] ins);
    int waited;
    waited = 0;
    s_valid_i <= 1'b1;
    instr_i   <= ins;
    pc_i      <= pc_next;
    pc_next    = pc_next + 32'd4;
    @(posedge clk);
    while (!s_ready_o && waited < HS_LIMIT) begin
      waited++;
      @(posedge clk);
    end
    if (!s_ready_o) begin
      log_problem("instruction was not accepted by the stage in time");
    end
    s_valid_i <= 1'b0;
  endtask

  task automatic write_reg(input logic [4:0] rd, input logic [31:0] val);
    wb_i <= '{wen: 1'b1, rd: rd, data: val};
    @(posedge clk);
    wb_i <= '0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (m_valid_o && waited < HS_LIMIT) begin
      waited++;
      @(posedge clk);
    end
    if (m_valid_o) begin
      log_problem("stage output did not drain in time");
    end
    @(posedge clk);
  endtask

  task automatic end_test(input string name);
    n_tests++;
    $display("test %s done with %0d errors", name, err_cnt - err_mark);
    err_mark = err_cnt;
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("tests failed");
    $finish;
  end

  initial begin
    logic [31:0] ins;
    logic [4:0]  rd;
    int          k;
    arst_n_i  = 1'b0;
    flush_i   = 1'b0;
    s_valid_i = 1'b0;
    instr_i   = '0;
    pc_i      = '0;
    wb_i      = '0;
    opcodes   = '{id_pkg::OP_LUI, id_pkg::OP_AUIPC, id_pkg::OP_JAL, id_pkg::OP_JALR,
                  id_pkg::OP_BRANCH, id_pkg::OP_LOAD, id_pkg::OP_STORE, id_pkg::OP_IMM,
                  id_pkg::OP_REG, 7'h7f};
    repeat (5) @(posedge clk);
    arst_n_i <= 1'b1;
    repeat (3) @(posedge clk);
    end_test("reset");

    // Fill every register, then try to clobber x0
    for (int r = 1; r < 32; r++) begin
      write_reg(r[4:0], $random(seed));
    end
    write_reg(5'd0, $random(seed));
    for (int i = 0; i < 10; i++) begin
      send(make_instr(id_pkg::OP_REG));
    end
    ins        = make_instr(id_pkg::OP_STORE);
    ins[19:15] = 5'd0;
    send(ins);
    for (int i = 0; i < 4; i++) begin
      rd         = 5'd1 + 5'({$random(seed)} % 31);
      ins        = make_instr(id_pkg::OP_REG);
      ins[19:15] = rd;
      wb_i      <= '{wen: 1'b1, rd: rd, data: $random(seed)};
      send(ins);
      wb_i      <= '0;
    end
    end_test("register_file");

    for (int i = 0; i < 30; i++) begin
      send(make_instr(opcodes[i % 10]));
    end
    end_test("decode");

    ins     = make_instr(id_pkg::OP_BRANCH);
    ins[31] = 1'b1;
    send(ins);
    ins[31] = 1'b0;
    send(ins);
    send(make_instr(id_pkg::OP_JAL));
    send(make_instr(id_pkg::OP_JALR));
    wait_drain();
    end_test("prediction");

    bp_pattern <= $random(seed);
    bp_en      <= 1'b1;
    for (int i = 0; i < 30; i++) begin
      k = {$random(seed)} % 10;
      send(make_instr(opcodes[k]));
    end
    bp_en <= 1'b0;
    wait_drain();
    end_test("back_pressure");

    // Flush while the next instruction is offered
    send(make_instr(id_pkg::OP_LOAD));
    s_valid_i <= 1'b1;
    instr_i   <= make_instr(id_pkg::OP_IMM);
    pc_i      <= pc_next;
    pc_next    = pc_next + 32'd4;
    flush_i   <= 1'b1;
    @(posedge clk);
    s_valid_i <= 1'b0;
    flush_i   <= 1'b0;
    repeat (3) @(posedge clk);
    // Flush an item held by a stalled EX
    bp_pattern <= '0;
    bp_en      <= 1'b1;
    @(posedge clk);
    send(make_instr(id_pkg::OP_JAL));
    repeat (2) @(posedge clk);
    flush_i <= 1'b1;
    @(posedge clk);
    flush_i <= 1'b0;
    bp_en   <= 1'b0;
    repeat (3) @(posedge clk);
    if (n_out_dut != n_out) begin
      log_problem("number of instructions leaving the stage differs from the model");
    end
    end_test("flush");

    $display("%0d tests run, %0d errors", n_tests, err_cnt);
    if (err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* decode_stage.f */
common/id_pkg.sv
decode/instr_decoder.sv
verilog/reg_file.sv
verilog/static_bpred.sv
verilog/id_ex_reg.sv
verilog/decode_stage.sv
testbench/decode_stage_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = decode_stage_tb
FILELIST  = decode_stage.f

SIM       = obj_dir/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
